//--- execute_stage.f
design/exec_pkg.sv
design/operand_bypass.sv
design/simd_alu.sv
design/lane_multiplier.sv
design/branch_resolver.sv
design/execute_stage.sv
dv/execute_stage_assert.sv
dv/execute_checker.sv
dv/execute_stage_tb.sv

//--- Makefile
TOP = execute_stage_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f execute_stage.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^Simulation passed$$'

lint:
	verilator --lint-only --timing --top-module $(TOP) -f execute_stage.f

clean:
	rm -rf obj_dir

//--- dv/execute_stage_tb.sv
// Execute stage testbench with clock, reset, stimulus table and watchdog
`timescale 1ns/100ps
`default_nettype none

module execute_stage_tb;
	import exec_pkg::*;

	localparam int MAX = 64;

	logic        clk;
	logic        arst_n;
	decoded_op_t op;
	reg_read_t   regs;
	writer_t     ma;
	writer_t     wb;
	writer_t     rf;
	logic [3:0]  flush;
	writer_t     ex;
	logic [31:0] ex_pc;
	logic        rollback;
	logic [31:0] rollback_pc;

	logic         issue;
	logic [127:0] chk_name;
	int           chk_delay;
	logic         chk_valid;
	logic [127:0] chk_value;
	logic [3:0]   chk_mask;
	logic [31:0]  chk_pc;
	logic         chk_roll;
	logic [31:0]  chk_target;
	int           checked;
	int           errors;

	logic [127:0] t_name [MAX];
	decoded_op_t  t_op [MAX];
	reg_read_t    t_regs [MAX];
	writer_t      t_ma [MAX];
	writer_t      t_wb [MAX];
	writer_t      t_rf [MAX];
	logic [3:0]   t_flush [MAX];
	int           t_delay [MAX];
	logic         t_valid [MAX];
	logic [127:0] t_value [MAX];
	logic [3:0]   t_mask [MAX];
	logic         t_roll [MAX];
	logic [31:0]  t_target [MAX];

	int          n;
	int          n_checks;
	int          seed;
	logic [31:0] pc_ctr;
	logic        built;
	writer_t     bp_ma;
	writer_t     bp_wb;
	writer_t     bp_rf;

	execute_stage i_dut (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.op_i         (op),
		.regs_i       (regs),
		.ma_i         (ma),
		.wb_i         (wb),
		.rf_i         (rf),
		.flush_i      (flush),
		.ex_o         (ex),
		.ex_pc_o      (ex_pc),
		.rollback_o   (rollback),
		.rollback_pc_o(rollback_pc)
	);

	execute_checker i_checker (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.ex_i         (ex),
		.ex_pc_i      (ex_pc),
		.rollback_i   (rollback),
		.rollback_pc_i(rollback_pc),
		.issue_i      (issue),
		.name_i       (chk_name),
		.delay_i      (chk_delay),
		.exp_valid_i  (chk_valid),
		.exp_value_i  (chk_value),
		.exp_mask_i   (chk_mask),
		.exp_pc_i     (chk_pc),
		.exp_roll_i   (chk_roll),
		.exp_target_i (chk_target),
		.checked_o    (checked),
		.errors_o     (errors)
	);

	bind execute_stage execute_stage_assert i_assert (.*);

	function automatic logic [127:0] vec4(input logic [31:0] l3, input logic [31:0] l2,
		input logic [31:0] l1, input logic [31:0] l0);
		return {l3, l2, l1, l0};
	endfunction

	function automatic logic [31:0] lane(input logic [127:0] v, input int i);
		return v[i*32 +: 32];
	endfunction

	function automatic decoded_op_t make_op(input alu_op_e aop, input logic op1v,
		input op2_src_e s2, input mask_src_e ms, input branch_e br, input logic [4:0] sel1,
		input logic [4:0] sel2, input logic [31:0] imm, input logic wbe,
		input logic [4:0] wreg, input logic wvec);
		decoded_op_t o;
		o.valid = 1'b1;
		o.pc = pc_ctr;
		o.alu_op = aop;
		o.op1_is_vector = op1v;
		o.op2_src = s2;
		o.mask_src = ms;
		o.branch = br;
		o.sel1 = sel1;
		o.sel2 = sel2;
		o.immediate = imm;
		o.has_writeback = wbe;
		o.writeback_reg = wreg;
		o.writeback_is_vector = wvec;
		return o;
	endfunction

	function automatic writer_t make_writer(input logic isvec, input logic [4:0] wreg,
		input logic [127:0] value, input logic [3:0] mask);
		writer_t w;
		w.valid = 1'b1;
		w.is_vector = isvec;
		w.writeback_reg = wreg;
		w.value = value;
		w.mask = mask;
		return w;
	endfunction

	task automatic rand_vec(output logic [127:0] v);
		for (int i = 0; i < 4; i++)
			v[i*32 +: 32] = $random(seed);
	endtask

	task automatic add_entry(input logic [127:0] name, input decoded_op_t o,
		input reg_read_t r, input logic [3:0] fl, input int dly, input logic ev,
		input logic [127:0] val, input logic [3:0] m, input logic rb, input logic [31:0] tgt);
		t_name[n] = name;
		t_op[n] = o;
		t_regs[n] = r;
		t_ma[n] = bp_ma;
		t_wb[n] = bp_wb;
		t_rf[n] = bp_rf;
		t_flush[n] = fl;
		t_delay[n] = dly;
		t_valid[n] = ev;
		t_value[n] = val;
		t_mask[n] = m;
		t_roll[n] = rb;
		t_target[n] = tgt;
		bp_ma = '0;
		bp_wb = '0;
		bp_rf = '0;
		if (dly > 0)
			n_checks++;
		n++;
		pc_ctr += 4;
	endtask

	// Idle slot with no op and no check
	task automatic add_idle(input logic [3:0] fl);
		add_entry("idle", '0, '0, fl, 0, 1'b0, '0, 4'h0, 1'b0, '0);
	endtask

	task automatic add_mul(input logic [127:0] name, input logic [4:0] wreg,
		input logic [3:0] fl, input logic ev);
		logic [127:0] va;
		logic [127:0] vb;
		logic [127:0] e;
		reg_read_t    r;
		rand_vec(va);
		rand_vec(vb);
		r = '0;
		r.vector1 = va;
		r.vector2 = vb;
		// Low 32 bits of each lane product
		for (int i = 0; i < 4; i++)
			e[i*32 +: 32] = lane(va, i) * lane(vb, i);
		add_entry(name, make_op(OP_MUL, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0,
			1, wreg, 1), r, fl, 4, ev, e, 4'hF, 1'b0, '0);
	endtask

	task automatic build_table();
		logic [127:0] va;
		logic [127:0] vb;
		logic [127:0] vc;
		logic [127:0] e;
		logic [31:0]  s1;
		logic [31:0]  s2;
		decoded_op_t  o;
		reg_read_t    r;

		// Plain ALU ops with no forwarding
		rand_vec(va);
		rand_vec(vb);
		r = '0;
		r.vector1 = va;
		r.vector2 = vb;
		for (int i = 0; i < 4; i++)
			e[i*32 +: 32] = lane(va, i) + lane(vb, i);
		o = make_op(OP_ADD, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0, 1, 10, 1);
		add_entry("add_vv", o, r, 0, 1, 1, e, 4'hF, 0, 0);

		for (int i = 0; i < 4; i++)
			e[i*32 +: 32] = lane(va, i) - 32'h11;
		o = make_op(OP_SUB, 1, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NONE, 1, 2, 32'h11, 1, 11, 1);
		add_entry("sub_imm", o, r, 0, 1, 1, e, 4'hF, 0, 0);

		s1 = $random(seed);
		s2 = $random(seed);
		r.scalar1 = s1;
		r.scalar2 = s2;
		o = make_op(OP_XOR, 0, OP2_SCALAR2, MASK_ALL_ONES, BR_NONE, 3, 4, 0, 1, 12, 1);
		add_entry("xor_ss", o, r, 0, 1, 1, {4{s1 ^ s2}}, 4'hF, 0, 0);

		for (int i = 0; i < 4; i++)
			e[i*32 +: 32] = lane(va, i) << 5;
		o = make_op(OP_SHL, 1, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NONE, 1, 2, 5, 1, 13, 1);
		add_entry("shl_imm", o, r, 0, 1, 1, e, 4'hF, 0, 0);

		for (int i = 0; i < 4; i++)
			e[i*32 +: 32] = lane(va, i) >> 3;
		o = make_op(OP_SHR, 1, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NONE, 1, 2, 3, 1, 19, 1);
		add_entry("shr_imm", o, r, 0, 1, 1, e, 4'hF, 0, 0);

		// Lanes 1 and 3 differ so lanes 0 and 2 compare equal
		vc = va ^ vec4(32'h1, 32'h0, 32'h1, 32'h0);
		r.vector2 = vc;
		o = make_op(OP_EQ, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0, 1, 14, 1);
		add_entry("eq_cmp", o, r, 0, 1, 1, 128'h5, 4'hF, 0, 0);
		o = make_op(OP_NE, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0, 1, 14, 1);
		add_entry("ne_cmp", o, r, 0, 1, 1, 128'hA, 4'hF, 0, 0);

		r.vector1 = vec4(32'hffff_fff8, 32'd7, 32'd5, 32'hffff_ffff);
		r.vector2 = vec4(32'hffff_fff7, 32'd9, 32'd5, 32'd0);
		o = make_op(OP_LTS, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0, 1, 15, 1);
		add_entry("lts_cmp", o, r, 0, 1, 1, 128'h5, 4'hF, 0, 0);
		o = make_op(OP_LTU, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0, 1, 16, 1);
		add_entry("ltu_cmp", o, r, 0, 1, 1, 128'h4, 4'hF, 0, 0);
		o = make_op(OP_GES, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0, 1, 16, 1);
		add_entry("ges_cmp", o, r, 0, 1, 1, 128'hA, 4'hF, 0, 0);

		r.vector1 = va;
		r.vector2 = vec4(32'd0, 32'd3, 32'd1, 32'd6);
		o = make_op(OP_SHUFFLE, 1, OP2_VECTOR2, MASK_ALL_ONES, BR_NONE, 1, 2, 0, 1, 17, 1);
		add_entry("shuffle", o, r, 0, 1, 1,
			vec4(lane(va, 0), lane(va, 3), lane(va, 1), lane(va, 2)), 4'hF, 0, 0);

		o = make_op(OP_MOVE, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_CALL, 3, 4, 32'h40, 1, 30, 0);
		add_entry("call", o, r, 0, 1, 1, {96'h0, o.pc}, 4'hF, 1, o.pc + 32'h40);

		// Scalar forwarding where ex beats ma
		o = make_op(OP_MOVE, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NONE, 3, 4, 32'h1234, 1, 7, 0);
		add_entry("fwd_set", o, r, 0, 1, 1, {4{32'h1234}}, 4'hF, 0, 0);
		r.scalar2 = 32'h9;
		bp_ma = make_writer(0, 7, {4{32'h5555}}, 4'hF);
		o = make_op(OP_MOVE, 0, OP2_SCALAR2, MASK_ALL_ONES, BR_NONE, 3, 7, 0, 1, 12, 0);
		add_entry("fwd_ex", o, r, 0, 1, 1, {4{32'h1234}}, 4'hF, 0, 0);
		// Vector writers never feed a scalar operand
		bp_ma = make_writer(1, 7, {4{32'h6666}}, 4'hF);
		bp_wb = make_writer(0, 7, {96'hdead, 32'h7777}, 4'h0);
		bp_rf = make_writer(0, 7, {96'hbeef, 32'h8888}, 4'hF);
		add_entry("fwd_wb", o, r, 0, 1, 1, {4{32'h7777}}, 4'hF, 0, 0);

		// Per-lane vector forwarding under masks
		r.scalar1 = 32'h1;
		o = make_op(OP_MOVE, 0, OP2_IMMEDIATE, MASK_SCALAR1, BR_NONE, 6, 4, 32'haaaa_0000,
			1, 5, 1);
		add_entry("mask_s1", o, r, 0, 1, 1, {4{32'haaaa_0000}}, 4'h1, 0, 0);
		rand_vec(va);
		rand_vec(vb);
		rand_vec(vc);
		bp_ma = make_writer(1, 5, va, 4'b0011);
		bp_wb = make_writer(1, 5, vb, 4'b0110);
		bp_rf = make_writer(1, 5, vc, 4'b1111);
		r.vector2 = '1;
		r.scalar2 = 32'ha;
		o = make_op(OP_MOVE, 0, OP2_VECTOR2, MASK_SCALAR2_INV, BR_NONE, 6, 5, 0, 1, 12, 1);
		add_entry("fwd_vec_lanes", o, r, 0, 1, 1,
			vec4(lane(vc, 3), lane(vb, 2), lane(va, 1), 32'haaaa_0000), 4'b0101, 0, 0);

		bp_rf = make_writer(0, 31, {4{32'hbad0}}, 4'hF);
		r.scalar1 = 32'h3;
		o = make_op(OP_MOVE, 0, OP2_SCALAR2, MASK_SCALAR1_INV, BR_NONE, 2, 31, 0, 1, 12, 0);
		add_entry("fwd_pc", o, r, 0, 1, 1, {4{o.pc}}, 4'b1100, 0, 0);

		r.scalar2 = 32'h6;
		r.vector1 = va;
		for (int i = 0; i < 4; i++)
			e[i*32 +: 32] = lane(va, i) & 32'h6;
		o = make_op(OP_AND, 1, OP2_SCALAR2, MASK_SCALAR2, BR_NONE, 1, 4, 0, 1, 18, 1);
		add_entry("mask_s2", o, r, 0, 1, 1, e, 4'b0110, 0, 0);

		// Branches
		r.vector1 = vec4(32'h0, 32'h0, 32'h0, 32'hf);
		o = make_op(OP_ADD, 1, OP2_IMMEDIATE, MASK_ALL_ONES, BR_ALL, 1, 2, 32'h80, 0, 0, 0);
		add_entry("br_all_taken", o, r, 0, 1, 0, '0, 4'h0, 1, o.pc + 32'h80);
		r.vector1 = vec4(32'h0, 32'h0, 32'h0, 32'h7);
		o = make_op(OP_ADD, 1, OP2_IMMEDIATE, MASK_ALL_ONES, BR_ALL, 1, 2, 32'h80, 0, 0, 0);
		add_entry("br_all_not", o, r, 0, 1, 0, '0, 4'h0, 0, 0);
		o = make_op(OP_ADD, 1, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NOT_ALL, 1, 2, 32'hc, 0, 0, 0);
		add_entry("br_notall", o, r, 0, 1, 0, '0, 4'h0, 1, o.pc + 32'hc);
		r.scalar1 = 32'h0;
		o = make_op(OP_ADD, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_ZERO, 3, 4, 32'hfff0, 0, 0, 0);
		add_entry("br_zero", o, r, 0, 1, 0, '0, 4'h0, 1, o.pc + 32'hfff0);
		o = make_op(OP_ADD, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NOT_ZERO, 3, 4, 8, 0, 0, 0);
		add_entry("br_nz_not", o, r, 0, 1, 0, '0, 4'h0, 0, 0);
		o = make_op(OP_ADD, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_ALWAYS, 3, 4, 32'h20, 0, 0, 0);
		add_entry("br_always", o, r, 0, 1, 0, '0, 4'h0, 1, o.pc + 32'h20);
		add_entry("br_flushed", o, r, 4'b0001, 1, 0, '0, 4'h0, 0, 0);
		r.scalar1 = 32'h100;
		o = make_op(OP_ADD, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NONE, 3, 4, 32'h20, 1, 31, 0);
		add_entry("pc_write", o, r, 0, 1, 1, {4{32'h120}}, 4'hF, 1, 32'h120);

		// Multiplies back to back and then interleaved with single-cycle ops
		add_mul("mul_0", 20, 0, 1);
		add_mul("mul_1", 21, 0, 1);
		add_mul("mul_2", 22, 0, 1);
		add_idle(0);
		add_idle(0);
		add_idle(0);
		add_mul("mul_a", 23, 0, 1);
		r.scalar1 = 32'h33;
		o = make_op(OP_MOVE, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NONE, 3, 4, 32'h77, 1, 12, 0);
		add_entry("slot_move", o, r, 0, 1, 1, {4{32'h77}}, 4'hF, 0, 0);
		add_mul("mul_b", 24, 0, 1);
		add_idle(0);
		o = make_op(OP_OR, 0, OP2_IMMEDIATE, MASK_ALL_ONES, BR_NONE, 3, 4, 32'h400, 1, 12, 0);
		add_entry("slot_or", o, r, 0, 1, 1, {4{32'h433}}, 4'hF, 0, 0);
		add_idle(0);

		// Multiplies killed at each stage
		add_mul("mul_fl_issue", 25, 4'b0001, 0);
		add_idle(0);
		add_idle(0);
		add_idle(0);
		add_mul("mul_fl_s2", 25, 0, 0);
		add_idle(4'b0010);
		add_idle(0);
		add_idle(0);
		add_mul("mul_fl_s3", 25, 0, 0);
		add_idle(0);
		add_idle(4'b0100);
		add_idle(0);
		add_mul("mul_fl_merge", 25, 0, 0);
		add_idle(0);
		add_idle(0);
		add_idle(4'b1000);
	endtask

	task automatic apply_entry(input int i);
		op = t_op[i];
		regs = t_regs[i];
		ma = t_ma[i];
		wb = t_wb[i];
		rf = t_rf[i];
		flush = t_flush[i];
		issue = t_delay[i] > 0;
		chk_name = t_name[i];
		chk_delay = t_delay[i];
		chk_valid = t_valid[i];
		chk_value = t_value[i];
		chk_mask = t_mask[i];
		chk_pc = t_op[i].pc;
		chk_roll = t_roll[i];
		chk_target = t_target[i];
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;
		op = '0;
		regs = '0;
		ma = '0;
		wb = '0;
		rf = '0;
		flush = '0;
		issue = 1'b0;
		chk_name = '0;
		chk_delay = 0;
		chk_valid = 1'b0;
		chk_value = '0;
		chk_mask = '0;
		chk_pc = '0;
		chk_roll = 1'b0;
		chk_target = '0;
		n = 0;
		n_checks = 0;
		seed = 32'h9aa4_a773;
		pc_ctr = 32'h1000;
		bp_ma = '0;
		bp_wb = '0;
		bp_rf = '0;
		built = 1'b0;
		build_table();
		built = 1'b1;

		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			apply_entry(i);
		end
		@(negedge clk);
		op = '0;
		ma = '0;
		wb = '0;
		rf = '0;
		flush = '0;
		issue = 1'b0;

		// Let the last multiplies drain
		repeat (6) @(posedge clk);
		@(negedge clk);
		if (checked != n_checks)
			$display("only %0d of %0d tests produced a result", checked, n_checks);
		$display("tests checked %0d of %0d, errors %0d", checked, n_checks, errors);
		if (errors == 0 && checked == n_checks)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (built);
		repeat ((n + 10) * 5) @(posedge clk);
		$display("watchdog expired before the tests completed");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/execute_checker.sv
// Result checker for the execute stage with expectations queued by due cycle
`timescale 1ns/100ps
`default_nettype none

module execute_checker (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  exec_pkg::writer_t          ex_i,
	input  logic [31:0]                ex_pc_i,
	input  logic                       rollback_i,
	input  logic [31:0]                rollback_pc_i,
	input  logic                       issue_i,
	input  logic [127:0]               name_i,
	input  int                         delay_i,
	input  logic                       exp_valid_i,
	input  logic [exec_pkg::VEC_W-1:0] exp_value_i,
	input  logic [exec_pkg::LANES-1:0] exp_mask_i,
	input  logic [31:0]                exp_pc_i,
	input  logic                       exp_roll_i,
	input  logic [31:0]                exp_target_i,
	output int                         checked_o,
	output int                         errors_o
);
	import exec_pkg::*;

	typedef struct packed {
		logic [127:0]     name;
		logic             valid;
		logic [VEC_W-1:0] value;
		logic [LANES-1:0] mask;
		logic [31:0]      pc;
		logic             fault;
	} pending_t;

	pending_t pending [int];
	pending_t p;
	int       cycle;
	logic     bad;

	initial
	begin
		checked_o = 0;
		errors_o = 0;
		cycle = 0;
	end

	// Sampled at the rising edge before the output register updates
	always @(posedge clk)
	begin
		if (!arst_n_i)
		begin
			if (ex_i.valid || rollback_i)
			begin
				errors_o++;
				$display("ex_o.valid or rollback_o is high while reset is held");
			end
		end
		else
		begin
			cycle++;
			if (pending.exists(cycle))
			begin
				p = pending[cycle];
				pending.delete(cycle);
				bad = p.fault;
				if (ex_i.valid !== p.valid)
				begin
					bad = 1'b1;
					$display("mismatch %0s valid expected %0b actual %0b",
						p.name, p.valid, ex_i.valid);
				end
				else if (p.valid && ex_i.value !== p.value)
				begin
					bad = 1'b1;
					$display("mismatch %0s value expected %h actual %h",
						p.name, p.value, ex_i.value);
				end
				else if (p.valid && ex_i.mask !== p.mask)
				begin
					bad = 1'b1;
					$display("mismatch %0s mask expected %b actual %b",
						p.name, p.mask, ex_i.mask);
				end
				else if (p.valid && ex_pc_i !== p.pc)
				begin
					bad = 1'b1;
					$display("mismatch %0s pc expected %h actual %h",
						p.name, p.pc, ex_pc_i);
				end
				if (bad)
					errors_o++;
				checked_o++;
				$display("test %0s %0s", p.name, bad ? "FAILED" : "ok");
			end

			// Rollback is combinational and checked in the issue cycle
			if (issue_i && delay_i > 0)
			begin
				p.name = name_i;
				p.valid = exp_valid_i;
				p.value = exp_value_i;
				p.mask = exp_mask_i;
				p.pc = exp_pc_i;
				p.fault = 1'b0;
				if (rollback_i !== exp_roll_i)
				begin
					p.fault = 1'b1;
					$display("mismatch %0s rollback expected %0b actual %0b",
						name_i, exp_roll_i, rollback_i);
				end
				else if (exp_roll_i && rollback_pc_i !== exp_target_i)
				begin
					p.fault = 1'b1;
					$display("mismatch %0s target expected %h actual %h",
						name_i, exp_target_i, rollback_pc_i);
				end
				pending[cycle + delay_i] = p;
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/execute_stage_assert.sv
// Bound assertions on the result merge, reset state and rollback qualification
`timescale 1ns/100ps
`default_nettype none

module execute_stage_assert (
	input logic                  clk,
	input logic                  arst_n_i,
	input exec_pkg::decoded_op_t op_i,
	input logic [3:0]            flush_i,
	input logic                  mul_done,
	input exec_pkg::wb_tag_t     mul_tag,
	input logic                  is_mul,
	input exec_pkg::writer_t     ex_o,
	input logic                  rollback_o
);

	// Issuer keeps writeback ops out of the multiply slot
	merge_conflict: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(mul_done && mul_tag.valid && !flush_i[3]
		&& op_i.valid && !flush_i[0] && !is_mul && op_i.has_writeback))
		else $error("multiply result and single-cycle writeback met at the merge");

	reset_clears_ex: assert property (@(posedge clk) !arst_n_i |-> !ex_o.valid)
		else $error("ex_o.valid high during reset");

	rollback_needs_op: assert property (@(posedge clk) disable iff (!arst_n_i)
		rollback_o |-> op_i.valid)
		else $error("rollback_o high without a valid op");

endmodule

`default_nettype wire

//--- design/execute_stage.sv
// Execute stage top with operand forwarding, operand and mask select,
// branch resolve and merge of single-cycle and multiply results
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  exec_pkg::decoded_op_t op_i,
	input  exec_pkg::reg_read_t   regs_i,
	input  exec_pkg::writer_t     ma_i,
	input  exec_pkg::writer_t     wb_i,
	input  exec_pkg::writer_t     rf_i,
	input  logic [3:0]            flush_i,
	output exec_pkg::writer_t     ex_o,
	output logic [31:0]           ex_pc_o,
	output logic                  rollback_o,
	output logic [31:0]           rollback_pc_o
);
	import exec_pkg::*;

	writer_t           writers [4];
	logic              issue_valid;
	logic              is_mul;
	logic [VEC_W-1:0]  operand1;
	logic [VEC_W-1:0]  bp2_value;
	logic [VEC_W-1:0]  operand2;
	logic [LANE_W-1:0] scalar1;
	logic [LANE_W-1:0] scalar2;
	logic [LANES-1:0]  mask_val;
	logic [VEC_W-1:0]  alu_result;
	wb_tag_t           mul_tag_in;
	logic              mul_done;
	logic [VEC_W-1:0]  mul_result;
	wb_tag_t           mul_tag;
	writer_t           ex_d;
	logic [31:0]       pc_d;
	writer_t           ex_q;
	logic              ex_valid_q;

	assign issue_valid = op_i.valid && !flush_i[0];
	assign is_mul = op_i.alu_op == OP_MUL;

	// Bypass sources, youngest first
	assign writers[0] = ex_o;
	assign writers[1] = ma_i;
	assign writers[2] = wb_i;
	assign writers[3] = rf_i;

	operand_bypass i_bypass1 (
		.sel_i        (op_i.sel1),
		.is_vector_i  (op_i.op1_is_vector),
		.pc_i         (op_i.pc),
		.read_vec_i   (regs_i.vector1),
		.read_scalar_i(regs_i.scalar1),
		.writers_i    (writers),
		.value_o      (operand1),
		.scalar_o     (scalar1)
	);

	operand_bypass i_bypass2 (
		.sel_i        (op_i.sel2),
		.is_vector_i  (op_i.op2_src == OP2_VECTOR2),
		.pc_i         (op_i.pc),
		.read_vec_i   (regs_i.vector2),
		.read_scalar_i(regs_i.scalar2),
		.writers_i    (writers),
		.value_o      (bp2_value),
		.scalar_o     (scalar2)
	);

	// Bypass 2 already broadcasts the scalar form
	assign operand2 = (op_i.op2_src == OP2_IMMEDIATE) ? {LANES{op_i.immediate}} : bp2_value;

	always_comb
	begin
		case (op_i.mask_src)
			MASK_SCALAR1:     mask_val = scalar1[LANES-1:0];
			MASK_SCALAR1_INV: mask_val = ~scalar1[LANES-1:0];
			MASK_SCALAR2:     mask_val = scalar2[LANES-1:0];
			MASK_SCALAR2_INV: mask_val = ~scalar2[LANES-1:0];
			default:          mask_val = '1;
		endcase
	end

	simd_alu i_alu (
		.op_i    (op_i.alu_op),
		.a_i     (operand1),
		.b_i     (operand2),
		.result_o(alu_result)
	);

	branch_resolver i_branch (
		.op_i       (op_i),
		.operand1_i (operand1),
		.alu_lane0_i(alu_result[LANE_W-1:0]),
		.active_i   (issue_valid),
		.rollback_o (rollback_o),
		.target_o   (rollback_pc_o)
	);

	assign mul_tag_in = '{
		valid:               op_i.has_writeback,
		pc:                  op_i.pc,
		writeback_reg:       op_i.writeback_reg,
		writeback_is_vector: op_i.writeback_is_vector,
		mask:                mask_val
	};

	lane_multiplier i_mul (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.start_i (issue_valid && is_mul),
		.a_i     (operand1),
		.b_i     (operand2),
		.tag_i   (mul_tag_in),
		.flush_i (flush_i[2:1]),
		.done_o  (mul_done),
		.result_o(mul_result),
		.tag_o   (mul_tag)
	);

	// Merge point, an emerging multiply owns the slot
	always_comb
	begin
		if (mul_done && !flush_i[3])
		begin
			ex_d.valid = mul_tag.valid;
			ex_d.is_vector = mul_tag.writeback_is_vector;
			ex_d.writeback_reg = mul_tag.writeback_reg;
			ex_d.value = mul_result;
			ex_d.mask = mul_tag.mask;
			pc_d = mul_tag.pc;
		end
		else
		begin
			ex_d.valid = issue_valid && !is_mul && op_i.has_writeback;
			ex_d.is_vector = op_i.writeback_is_vector;
			ex_d.writeback_reg = op_i.writeback_reg;
			// Call saves the PC as the link value
			if (op_i.branch == BR_CALL)
				ex_d.value = {{(VEC_W-32){1'b0}}, op_i.pc};
			else
				ex_d.value = alu_result;
			ex_d.mask = mask_val;
			pc_d = op_i.pc;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			ex_valid_q <= 1'b0;
		else
			ex_valid_q <= ex_d.valid;
	end

	always_ff @(posedge clk)
	begin
		ex_q <= ex_d;
		ex_pc_o <= pc_d;
	end

	always_comb
	begin
		ex_o = ex_q;
		ex_o.valid = ex_valid_q;
	end

endmodule

`default_nettype wire

//--- design/branch_resolver.sv
// Branch condition evaluation and rollback target
`timescale 1ns/100ps
`default_nettype none

module branch_resolver (
	input  exec_pkg::decoded_op_t       op_i,
	input  logic [exec_pkg::VEC_W-1:0]  operand1_i,
	input  logic [exec_pkg::LANE_W-1:0] alu_lane0_i,
	input  logic                        active_i,
	output logic                        rollback_o,
	output logic [31:0]                 target_o
);
	import exec_pkg::*;

	logic all_set;
	logic lane0_zero;
	logic writes_pc;
	logic taken;

	// Mask bits from a lane compare sit in the low bits
	assign all_set = &operand1_i[LANES-1:0];
	assign lane0_zero = operand1_i[LANE_W-1:0] == '0;

	// Arithmetic write to the PC acts as a jump
	assign writes_pc = op_i.has_writeback && !op_i.writeback_is_vector
		&& op_i.writeback_reg == REG_PC;

	always_comb
	begin
		case (op_i.branch)
			BR_ALL:      taken = all_set;
			BR_NOT_ALL:  taken = !all_set;
			BR_ZERO:     taken = lane0_zero;
			BR_NOT_ZERO: taken = !lane0_zero;
			BR_ALWAYS:   taken = 1'b1;
			BR_CALL:     taken = 1'b1;
			default:     taken = writes_pc;
		endcase
	end

	assign rollback_o = active_i && taken;
	assign target_o = (op_i.branch == BR_NONE) ? alu_lane0_i : op_i.pc + op_i.immediate;

endmodule

`default_nettype wire

//--- design/lane_multiplier.sv
// Three-stage lane multiplier, low 32 bits of each product,
// with the writeback tag carried alongside
`timescale 1ns/100ps
`default_nettype none

module lane_multiplier (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       start_i,
	input  logic [exec_pkg::VEC_W-1:0] a_i,
	input  logic [exec_pkg::VEC_W-1:0] b_i,
	input  exec_pkg::wb_tag_t          tag_i,
	input  logic [1:0]                 flush_i,
	output logic                       done_o,
	output logic [exec_pkg::VEC_W-1:0] result_o,
	output exec_pkg::wb_tag_t          tag_o
);
	import exec_pkg::*;

	localparam int HALF_W = LANE_W / 2;

	logic [MUL_STAGES-1:0] valid_q;
	wb_tag_t               tag_q [MUL_STAGES];

	// Stage 1: half-width partial products
	logic [LANES-1:0][LANE_W-1:0] ll_q;
	logic [LANES-1:0][HALF_W-1:0] lh_q;
	logic [LANES-1:0][HALF_W-1:0] hl_q;
	// Stage 2: cross terms folded together
	logic [LANES-1:0][LANE_W-1:0] low_q;
	logic [LANES-1:0][HALF_W-1:0] cross_q;
	// Stage 3: final sum
	logic [VEC_W-1:0]             prod_q;

	// flush_i[0] kills the op leaving stage 1, flush_i[1] the one leaving stage 2
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			valid_q <= '0;
		else
		begin
			valid_q[0] <= start_i;
			valid_q[1] <= valid_q[0] && !flush_i[0];
			valid_q[2] <= valid_q[1] && !flush_i[1];
		end
	end

	always_ff @(posedge clk)
	begin
		tag_q[0] <= tag_i;
		for (int s = 1; s < MUL_STAGES; s++)
			tag_q[s] <= tag_q[s-1];

		for (int l = 0; l < LANES; l++)
		begin
			ll_q[l] <= {{HALF_W{1'b0}}, a_i[l*LANE_W +: HALF_W]}
				* {{HALF_W{1'b0}}, b_i[l*LANE_W +: HALF_W]};
			// Only the low half of the cross terms reaches the result
			lh_q[l] <= a_i[l*LANE_W +: HALF_W] * b_i[l*LANE_W + HALF_W +: HALF_W];
			hl_q[l] <= a_i[l*LANE_W + HALF_W +: HALF_W] * b_i[l*LANE_W +: HALF_W];

			low_q[l] <= ll_q[l];
			cross_q[l] <= lh_q[l] + hl_q[l];

			prod_q[l*LANE_W +: LANE_W] <= low_q[l] + {cross_q[l], {HALF_W{1'b0}}};
		end
	end

	assign done_o = valid_q[MUL_STAGES-1];
	assign result_o = prod_q;

	always_comb
	begin
		tag_o = tag_q[MUL_STAGES-1];
		tag_o.valid = tag_q[MUL_STAGES-1].valid && valid_q[MUL_STAGES-1];
	end

endmodule

`default_nettype wire

//--- design/simd_alu.sv
// Single-cycle lane ALU with arithmetic, logic, shifts,
// coalesced compares and lane shuffle
`timescale 1ns/100ps
`default_nettype none

module simd_alu (
	input  exec_pkg::alu_op_e          op_i,
	input  logic [exec_pkg::VEC_W-1:0] a_i,
	input  logic [exec_pkg::VEC_W-1:0] b_i,
	output logic [exec_pkg::VEC_W-1:0] result_o
);
	import exec_pkg::*;

	localparam int SH_W = $clog2(LANE_W);

	logic [VEC_W-1:0] lane_result;
	logic [LANES-1:0] cmp_bits;
	logic             is_cmp;

	assign is_cmp = op_i inside {OP_EQ, OP_NE, OP_LTS, OP_LTU, OP_GES};

	always_comb
	begin
		logic [LANE_W-1:0] la;
		logic [LANE_W-1:0] lb;
		logic [LANE_W-1:0] res;
		logic [1:0]        src_lane;

		lane_result = '0;
		cmp_bits = '0;
		for (int i = 0; i < LANES; i++)
		begin
			la = a_i[i*LANE_W +: LANE_W];
			lb = b_i[i*LANE_W +: LANE_W];
			src_lane = lb[1:0];
			res = '0;
			case (op_i)
				OP_ADD:     res = la + lb;
				OP_SUB:     res = la - lb;
				OP_AND:     res = la & lb;
				OP_OR:      res = la | lb;
				OP_XOR:     res = la ^ lb;
				OP_SHL:     res = la << lb[SH_W-1:0];
				OP_SHR:     res = la >> lb[SH_W-1:0];
				OP_EQ:      cmp_bits[i] = la == lb;
				OP_NE:      cmp_bits[i] = la != lb;
				OP_LTS:     cmp_bits[i] = $signed(la) < $signed(lb);
				OP_LTU:     cmp_bits[i] = la < lb;
				OP_GES:     cmp_bits[i] = $signed(la) >= $signed(lb);
				// Operand 2 lane picks the source lane, modulo lane count
				OP_SHUFFLE: res = a_i[src_lane*LANE_W +: LANE_W];
				OP_MOVE:    res = lb;
				// MUL takes the pipelined path
				default:    res = '0;
			endcase
			lane_result[i*LANE_W +: LANE_W] = res;
		end
	end

	// Compare results pack into the low bits, one per lane
	assign result_o = is_cmp ? {{(VEC_W-LANES){1'b0}}, cmp_bits} : lane_result;

endmodule

`default_nettype wire

//--- design/operand_bypass.sv
// Source operand forwarding from the four younger writers,
// scalar by register match and vector per lane under mask
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
	input  logic [exec_pkg::REG_IDX_W-1:0] sel_i,
	input  logic                           is_vector_i,
	input  logic [31:0]                    pc_i,
	input  logic [exec_pkg::VEC_W-1:0]     read_vec_i,
	input  logic [exec_pkg::LANE_W-1:0]    read_scalar_i,
	input  exec_pkg::writer_t              writers_i [4],
	output logic [exec_pkg::VEC_W-1:0]     value_o,
	output logic [exec_pkg::LANE_W-1:0]    scalar_o
);
	import exec_pkg::*;

	logic [$size(writers_i)-1:0] scalar_hit;
	logic [$size(writers_i)-1:0] vector_hit;
	logic [VEC_W-1:0]            vec_value;

	// Register matches per writer, index 0 is the youngest
	always_comb
	begin
		for (int w = 0; w < $size(writers_i); w++)
		begin
			scalar_hit[w] = writers_i[w].valid && !writers_i[w].is_vector
				&& writers_i[w].writeback_reg == sel_i;
			vector_hit[w] = writers_i[w].valid && writers_i[w].is_vector
				&& writers_i[w].writeback_reg == sel_i;
		end
	end

	// Walk oldest to youngest so the youngest match wins
	always_comb
	begin
		scalar_o = read_scalar_i;
		for (int w = $size(writers_i) - 1; w >= 0; w--)
		begin
			if (scalar_hit[w])
				scalar_o = writers_i[w].value[LANE_W-1:0];
		end

		// PC alias overrides any forwarded value
		if (sel_i == REG_PC)
			scalar_o = pc_i;
	end

	always_comb
	begin
		vec_value = read_vec_i;
		for (int w = $size(writers_i) - 1; w >= 0; w--)
		begin
			for (int l = 0; l < LANES; l++)
			begin
				// Lanes the writer does not touch keep the older value
				if (vector_hit[w] && writers_i[w].mask[l])
					vec_value[l*LANE_W +: LANE_W] = writers_i[w].value[l*LANE_W +: LANE_W];
			end
		end
	end

	// Scalars are broadcast to every lane
	assign value_o = is_vector_i ? vec_value : {LANES{scalar_o}};

endmodule

`default_nettype wire

//--- design/exec_pkg.sv
// Shared sizes, operation encodings and payload structs
// for the SIMD execute stage
`default_nettype none

package exec_pkg;

	localparam int LANES      = 4;
	localparam int LANE_W     = 32;
	localparam int VEC_W      = LANES * LANE_W;
	localparam int REG_IDX_W  = 5;
	localparam int MUL_STAGES = 3;

	// Scalar register index that aliases the PC
	localparam logic [REG_IDX_W-1:0] REG_PC = 5'd31;

	// MUL is the only multi-cycle operation
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SHL,
		OP_SHR,
		OP_EQ,
		OP_NE,
		OP_LTS,
		OP_LTU,
		OP_GES,
		OP_SHUFFLE,
		OP_MUL,
		OP_MOVE
	} alu_op_e;

	typedef enum logic [1:0] {
		OP2_SCALAR2,
		OP2_VECTOR2,
		OP2_IMMEDIATE
	} op2_src_e;

	typedef enum logic [2:0] {
		MASK_SCALAR1,
		MASK_SCALAR1_INV,
		MASK_SCALAR2,
		MASK_SCALAR2_INV,
		MASK_ALL_ONES
	} mask_src_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ALL,
		BR_ZERO,
		BR_NOT_ZERO,
		BR_ALWAYS,
		BR_CALL,
		BR_NOT_ALL
	} branch_e;

	typedef struct packed {
		logic                 valid;
		logic [31:0]          pc;
		alu_op_e              alu_op;
		logic                 op1_is_vector;
		op2_src_e             op2_src;
		mask_src_e            mask_src;
		branch_e              branch;
		logic [REG_IDX_W-1:0] sel1;
		logic [REG_IDX_W-1:0] sel2;
		logic [31:0]          immediate;
		logic                 has_writeback;
		logic [REG_IDX_W-1:0] writeback_reg;
		logic                 writeback_is_vector;
	} decoded_op_t;

	typedef struct packed {
		logic [LANE_W-1:0] scalar1;
		logic [LANE_W-1:0] scalar2;
		logic [VEC_W-1:0]  vector1;
		logic [VEC_W-1:0]  vector2;
	} reg_read_t;

	// valid means a register write is pending from this stage
	typedef struct packed {
		logic                 valid;
		logic                 is_vector;
		logic [REG_IDX_W-1:0] writeback_reg;
		logic [VEC_W-1:0]     value;
		logic [LANES-1:0]     mask;
	} writer_t;

	typedef struct packed {
		logic                 valid;
		logic [31:0]          pc;
		logic [REG_IDX_W-1:0] writeback_reg;
		logic                 writeback_is_vector;
		logic [LANES-1:0]     mask;
	} wb_tag_t;

endpackage

`default_nettype wire
